/* list.f */
logic/line_pkg.sv
logic/ctrl_pkg.sv
logic/request_splitter.sv
logic/beat_lane.sv
logic/line_merger.sv
logic/dcache_line_ctrl.sv
bench/bank_model.sv
bench/tb_dcache_line_ctrl.sv

/* bench/tb_dcache_line_ctrl.sv */
// Clock, reset, watchdog, directed tests and checks for the data cache line controller
module tb_dcache_line_ctrl
	import line_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          CLK_PERIOD      = 8;
	localparam int          RESET_CYCLES    = 5;
	localparam int          ADR_W           = 26;
	localparam int          NLINES          = 16;
	localparam logic [31:0] SEED            = 32'h8c98;
	localparam int          NUM_TESTS       = 6;
	localparam int          WATCHDOG_CYCLES = NUM_TESTS * 200;
	localparam int          ACK_LIMIT       = 150;
	localparam int          HOLD_CYCLES     = 10;
	localparam int          BEAT_BYTES      = $bits(beat_be_t);

	logic clk;
	logic rst;
	logic cpu_req;
	logic cpu_we;
	logic cpu_nc;
	logic hit;
	logic [ADR_W-1:0] cpu_adr;
	line_sel_t cpu_sel;
	line_t cpu_dat;
	line_t cache_dat;
	logic cpu_ack;
	logic line_wr;
	line_t line_dat;
	logic [BEATS-1:0] bank_req;
	logic [BEATS-1:0] bank_we;
	logic [BEATS-1:0][ADR_W+1:0] bank_adr;
	beat_be_t [BEATS-1:0] bank_be;
	beat_t [BEATS-1:0] bank_wdat;
	logic [BEATS-1:0] bank_ack;
	beat_t [BEATS-1:0] bank_rdat;

	int errors = 0;
	int checks = 0;

	// Expected memory contents, one line per address
	line_t shadow [NLINES];

	// Bank traffic seen by the monitor
	logic [BEATS-1:0] req_seen = '0;
	int rd_beat [BEATS] = '{default: 0};
	int wr_beat [BEATS] = '{default: 0};
	beat_be_t last_be [BEATS];
	int wr_pulses = 0;

	// Counter values at the start of a request
	int rd_base [BEATS];
	int wr_base [BEATS];
	int pulse_base;

	dcache_line_ctrl #(
		.ADR_W(ADR_W)
	) DUT (
		.clk_i      (clk),
		.rst_i      (rst),
		.cpu_req_i  (cpu_req),
		.cpu_we_i   (cpu_we),
		.cpu_nc_i   (cpu_nc),
		.cpu_adr_i  (cpu_adr),
		.cpu_sel_i  (cpu_sel),
		.cpu_dat_i  (cpu_dat),
		.hit_i      (hit),
		.cache_dat_i(cache_dat),
		.cpu_ack_o  (cpu_ack),
		.line_wr_o  (line_wr),
		.line_dat_o (line_dat),
		.bank_req_o (bank_req),
		.bank_we_o  (bank_we),
		.bank_adr_o (bank_adr),
		.bank_be_o  (bank_be),
		.bank_wdat_o(bank_wdat),
		.bank_ack_i (bank_ack),
		.bank_rdat_i(bank_rdat)
	);

	bank_model #(
		.ADR_W (ADR_W),
		.NLINES(NLINES),
		.SEED  (SEED)
	) banks (
		.clk_i (clk),
		.rst_i (rst),
		.req_i (bank_req),
		.we_i  (bank_we),
		.adr_i (bank_adr),
		.be_i  (bank_be),
		.wdat_i(bank_wdat),
		.ack_o (bank_ack),
		.rdat_o(bank_rdat)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	// Counts bank request starts and cache write pulses and checks each bank address
	always @(posedge clk) begin
		for (int b = 0; b < BEATS; b++) begin
			if (bank_req[b] && !req_seen[b]) begin
				check_adr($sformatf("bank_adr_o[%0d]", b), bank_adr[b],
					{cpu_adr, beat_idx_t'(b)});
				if (bank_we[b]) begin
					wr_beat[b] <= wr_beat[b] + 1;
					last_be[b] <= bank_be[b];
				end else begin
					rd_beat[b] <= rd_beat[b] + 1;
				end
			end
		end
		if (line_wr)
			wr_pulses <= wr_pulses + 1;
		req_seen <= bank_req;
	end

	// ==================================================
	// Compare tasks
	// ==================================================

	task automatic check_line(input string name, input line_t got, input line_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_be(input string name, input beat_be_t got, input beat_be_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_adr(input string name, input logic [ADR_W+1:0] got,
			input logic [ADR_W+1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ==================================================
	// Helpers
	// ==================================================

	function automatic line_t fill_line(input logic [31:0] tag);
		line_t l;
		for (int w = 0; w < 16; w++)
			l[w*32 +: 32] = tag ^ (32'(w) * 32'h01030507);
		return l;
	endfunction

	// Selected CPU bytes replace the bytes of the base line
	function automatic line_t merge_bytes(input line_t base, input line_sel_t sel,
			input line_t dat);
		line_t l;
		l = base;
		for (int i = 0; i < $bits(line_sel_t); i++)
			if (sel[i])
				l[i*8 +: 8] = dat[i*8 +: 8];
		return l;
	endfunction

	function automatic int reads_since();
		int n;
		n = 0;
		for (int b = 0; b < BEATS; b++)
			n += rd_beat[b] - rd_base[b];
		return n;
	endfunction

	function automatic int writes_since();
		int n;
		n = 0;
		for (int b = 0; b < BEATS; b++)
			n += wr_beat[b] - wr_base[b];
		return n;
	endfunction

	task automatic load_shadow();
		for (int i = 0; i < NLINES; i++)
			for (int b = 0; b < BEATS; b++)
				shadow[i][b*128 +: 128] = banks.mem[b][i];
	endtask

	task automatic take_snapshot();
		for (int b = 0; b < BEATS; b++) begin
			rd_base[b] = rd_beat[b];
			wr_base[b] = wr_beat[b];
		end
		pulse_base = wr_pulses;
	endtask

	// Edges until cpu_ack_o is seen at the given level
	task automatic wait_ack(input logic level, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (cpu_ack !== level && cycles < ACK_LIMIT);
		if (cpu_ack !== level) begin
			errors++;
			$display("Timeout: cpu_ack_o did not go to %0b within %0d cycles", level, ACK_LIMIT);
		end
	endtask

	// Runs a full CPU handshake and returns the line and the request to ack latency
	task automatic issue_request(input logic we, input logic nc, input logic h,
			input logic [ADR_W-1:0] adr, input line_sel_t sel, input line_t dat,
			input line_t cdat, output line_t line, output int latency);
		int cycles;
		take_snapshot();
		@(posedge clk);
		cpu_req   <= 1'b1;
		cpu_we    <= we;
		cpu_nc    <= nc;
		hit       <= h;
		cpu_adr   <= adr;
		cpu_sel   <= sel;
		cpu_dat   <= dat;
		cache_dat <= cdat;
		wait_ack(1'b1, cycles);
		// Ack is sampled one edge after it rises
		latency = cycles - 1;
		line = line_dat;
		cpu_req <= 1'b0;
		wait_ack(1'b0, cycles);
	endtask

	task automatic check_bank_writes(input line_sel_t sel);
		beat_be_t be;
		for (int b = 0; b < BEATS; b++) begin
			be = sel[b*BEAT_BYTES +: BEAT_BYTES];
			check_count($sformatf("bank %0d writes", b), wr_beat[b] - wr_base[b],
				(|be) ? 1 : 0);
			if (|be)
				check_be($sformatf("bank_be_o[%0d]", b), last_be[b], be);
		end
	endtask

	task automatic check_read_miss(input logic [ADR_W-1:0] adr);
		line_t line;
		int lat;
		issue_request(1'b0, 1'b0, 1'b0, adr, '1, '0, '0, line, lat);
		check_line("line_dat_o", line, shadow[adr]);
		check_count("line_wr_o pulses", wr_pulses - pulse_base, 1);
		check_count("bank reads", reads_since(), 4);
		check_count("bank writes", writes_since(), 0);
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_reset_and_hold();
		int cycles;
		check_bit("cpu_ack_o", cpu_ack, 1'b0);
		check_bit("line_wr_o", line_wr, 1'b0);
		check_bit("bank_req_o", |bank_req, 1'b0);
		@(posedge clk);
		cpu_req   <= 1'b1;
		cpu_we    <= 1'b0;
		cpu_nc    <= 1'b0;
		hit       <= 1'b1;
		cpu_adr   <= 1;
		cpu_sel   <= '1;
		cache_dat <= fill_line(32'h0bad_0001);
		wait_ack(1'b1, cycles);
		repeat (HOLD_CYCLES) begin
			@(posedge clk);
			check_bit("cpu_ack_o", cpu_ack, 1'b1);
			check_bit("bank_req_o", |bank_req, 1'b0);
		end
		cpu_req <= 1'b0;
		wait_ack(1'b0, cycles);
	endtask

	task automatic test_read_hit();
		line_t line;
		line_t cdat;
		int lat;
		cdat = fill_line(32'hcafe_0005);
		issue_request(1'b0, 1'b0, 1'b1, 5, '1, '0, cdat, line, lat);
		check_line("line_dat_o", line, cdat);
		check_count("line_wr_o pulses", wr_pulses - pulse_base, 0);
		check_count("bank requests", reads_since() + writes_since(), 0);
		check_count("hit latency", lat, 3);
	endtask

	task automatic test_nc_read();
		line_t line;
		line_t exp;
		int lat;
		// One byte in beat 1 and one in beat 3
		issue_request(1'b0, 1'b1, 1'b0, 7, 64'h0001_0000_8000_0000, '0, '0, line, lat);
		exp = '0;
		exp[128 +: 128] = shadow[7][128 +: 128];
		exp[384 +: 128] = shadow[7][384 +: 128];
		check_line("line_dat_o", line, exp);
		check_count("bank reads", reads_since(), 2);
		check_count("bank writes", writes_since(), 0);
		check_count("line_wr_o pulses", wr_pulses - pulse_base, 0);
	endtask

	task automatic test_write_hit();
		line_t line;
		line_t dat;
		line_t cdat;
		line_sel_t sel;
		int lat;
		sel  = 64'h0000_0f0f_0000_0033;
		dat  = fill_line(32'h1234_9009);
		cdat = fill_line(32'h5a5a_0009);
		issue_request(1'b1, 1'b0, 1'b1, 9, sel, dat, cdat, line, lat);
		check_line("line_dat_o", line, merge_bytes(cdat, sel, dat));
		check_count("line_wr_o pulses", wr_pulses - pulse_base, 1);
		check_count("bank reads", reads_since(), 0);
		check_bank_writes(sel);
		shadow[9] = merge_bytes(shadow[9], sel, dat);
		check_read_miss(9);
	endtask

	task automatic test_write_miss();
		line_t line;
		line_t dat;
		line_sel_t sel;
		int lat;
		// Beat 0 has no selected byte and must be skipped
		sel = 64'hf000_00ff_0180_0000;
		dat = fill_line(32'h7e57_000b);
		issue_request(1'b1, 1'b0, 1'b0, 11, sel, dat, '0, line, lat);
		// Without a cache line the unselected bytes come from lanes that read nothing
		check_line("line_dat_o", line, merge_bytes('0, sel, dat));
		check_count("line_wr_o pulses", wr_pulses - pulse_base, 0);
		check_count("bank reads", reads_since(), 0);
		check_bank_writes(sel);
		shadow[11] = merge_bytes(shadow[11], sel, dat);
		check_read_miss(11);
	endtask

	initial begin
		rst       = 1'b1;
		cpu_req   = 1'b0;
		cpu_we    = 1'b0;
		cpu_nc    = 1'b0;
		hit       = 1'b0;
		cpu_adr   = '0;
		cpu_sel   = '0;
		cpu_dat   = '0;
		cache_dat = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		load_shadow();

		test_reset_and_hold();
		check_read_miss(3);
		test_read_hit();
		test_nc_read();
		test_write_hit();
		test_write_miss();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* bench/bank_model.sv */
// Four beat-interleaved memory banks with random ack delay and byte-enable writes
module bank_model
	import line_pkg::*;
#(
	parameter int          ADR_W  = 26,
	parameter int          NLINES = 16,
	parameter logic [31:0] SEED   = 32'h8c98
) (
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic [BEATS-1:0]            req_i,
	input  logic [BEATS-1:0]            we_i,
	input  logic [BEATS-1:0][ADR_W+1:0] adr_i,
	input  beat_be_t [BEATS-1:0]        be_i,
	input  beat_t [BEATS-1:0]           wdat_i,
	output logic [BEATS-1:0]            ack_o,
	output beat_t [BEATS-1:0]           rdat_o
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IDX_W = $clog2(NLINES);

	// Bank b holds beat b of every line
	beat_t mem [BEATS][NLINES];
	logic [2:0] delay [BEATS];
	logic [31:0] rng;
	logic [IDX_W-1:0] idx;

	function automatic logic [31:0] lcg(input logic [31:0] x);
		return x * 32'd1664525 + 32'd1013904223;
	endfunction

	// Fill value from the full beat address, line and beat number together
	function automatic beat_t pattern(input int line, input int beat);
		logic [31:0] a;
		beat_t d;
		a = 32'(line * BEATS + beat);
		for (int w = 0; w < 4; w++)
			d[w*32 +: 32] = (a + 32'd1) * 32'h9e3779b1 + 32'(w) * 32'h01010101;
		return d;
	endfunction

	initial begin
		for (int b = 0; b < BEATS; b++)
			for (int i = 0; i < NLINES; i++)
				mem[b][i] = pattern(i, b);
	end

	// ==================================================
	// Four-phase responder, one per bank
	// ==================================================

	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_o  <= '0;
			rdat_o <= '0;
			rng = SEED;
			for (int b = 0; b < BEATS; b++) begin
				rng = lcg(rng);
				delay[b] = rng[18:16];
			end
		end else begin
			for (int b = 0; b < BEATS; b++) begin
				idx = adr_i[b][2 +: IDX_W];
				if (req_i[b] && !ack_o[b]) begin
					if (delay[b] != 3'd0) begin
						delay[b] = delay[b] - 3'd1;
					end else begin
						if (we_i[b]) begin
							for (int k = 0; k < $bits(beat_be_t); k++)
								if (be_i[b][k])
									mem[b][idx][k*8 +: 8] = wdat_i[b][k*8 +: 8];
						end else begin
							rdat_o[b] <= mem[b][idx];
						end
						ack_o[b] <= 1'b1;
						// Next delay for this bank
						rng = lcg(rng);
						delay[b] = rng[18:16];
					end
				end else if (!req_i[b] && ack_o[b]) begin
					ack_o[b] <= 1'b0;
				end
			end
		end
	end

endmodule

/* logic/dcache_line_ctrl.sv */
// Data cache line controller top: splitter, per-beat lanes and line merger
module dcache_line_ctrl
	import line_pkg::*, ctrl_pkg::*;
#(
	parameter int ADR_W = 26
) (
	input  logic                          clk_i,
	input  logic                          rst_i,
	// CPU side
	input  logic                          cpu_req_i,
	input  logic                          cpu_we_i,
	input  logic                          cpu_nc_i,
	input  logic [ADR_W-1:0]              cpu_adr_i,
	input  line_sel_t                     cpu_sel_i,
	input  line_t                         cpu_dat_i,
	input  logic                          hit_i,
	input  line_t                         cache_dat_i,
	output logic                          cpu_ack_o,
	output logic                          line_wr_o,
	output line_t                         line_dat_o,
	// Memory banks, one per beat
	output logic [BEATS-1:0]              bank_req_o,
	output logic [BEATS-1:0]              bank_we_o,
	output logic [BEATS-1:0][ADR_W+1:0]   bank_adr_o,
	output beat_be_t [BEATS-1:0]          bank_be_o,
	output beat_t [BEATS-1:0]             bank_wdat_o,
	input  logic [BEATS-1:0]              bank_ack_i,
	input  beat_t [BEATS-1:0]             bank_rdat_i
);

	localparam int BEAT_BITS  = $bits(beat_t);
	localparam int BEAT_BYTES = $bits(beat_be_t);

	logic lane_go;
	beat_op_e [BEATS-1:0] lane_op;
	logic [ADR_W-1:0] req_adr;
	logic req_we;
	line_sel_t req_sel;
	line_t req_dat;
	logic use_cache;
	logic upd_line;
	logic line_clr;
	logic [BEATS-1:0] lane_done;
	beat_t [BEATS-1:0] lane_rdat;

	// ==================================================
	// Request split
	// ==================================================

	request_splitter #(
		.ADR_W(ADR_W)
	) u_splitter (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cpu_req_i  (cpu_req_i),
		.cpu_we_i   (cpu_we_i),
		.cpu_nc_i   (cpu_nc_i),
		.hit_i      (hit_i),
		.cpu_adr_i  (cpu_adr_i),
		.cpu_sel_i  (cpu_sel_i),
		.cpu_dat_i  (cpu_dat_i),
		.line_clr_i (line_clr),
		.lane_go_o  (lane_go),
		.lane_op_o  (lane_op),
		.req_adr_o  (req_adr),
		.req_we_o   (req_we),
		.req_sel_o  (req_sel),
		.req_dat_o  (req_dat),
		.use_cache_o(use_cache),
		.upd_line_o (upd_line)
	);

	// ==================================================
	// Beat lanes
	// ==================================================

	for (genvar b = 0; b < BEATS; b++) begin : g_lane
		beat_lane #(
			.ADR_W(ADR_W)
		) u_lane (
			.clk_i      (clk_i),
			.rst_i      (rst_i),
			.go_i       (lane_go),
			.op_i       (lane_op[b]),
			.adr_i      (req_adr),
			.beat_i     (beat_idx_t'(b)),
			.wdat_i     (req_dat[b*BEAT_BITS +: BEAT_BITS]),
			.be_i       (req_sel[b*BEAT_BYTES +: BEAT_BYTES]),
			.bank_ack_i (bank_ack_i[b]),
			.bank_rdat_i(bank_rdat_i[b]),
			.clr_i      (line_clr),
			.bank_req_o (bank_req_o[b]),
			.bank_we_o  (bank_we_o[b]),
			.bank_adr_o (bank_adr_o[b]),
			.bank_be_o  (bank_be_o[b]),
			.bank_wdat_o(bank_wdat_o[b]),
			.done_o     (lane_done[b]),
			.rdat_o     (lane_rdat[b])
		);
	end

	// ==================================================
	// Line assembly
	// ==================================================

	line_merger u_merger (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.cpu_req_i  (cpu_req_i),
		.lane_done_i(lane_done),
		.lane_rdat_i(lane_rdat),
		.req_we_i   (req_we),
		.req_sel_i  (req_sel),
		.req_dat_i  (req_dat),
		.use_cache_i(use_cache),
		.upd_line_i (upd_line),
		.cache_dat_i(cache_dat_i),
		.line_clr_o (line_clr),
		.cpu_ack_o  (cpu_ack_o),
		.line_wr_o  (line_wr_o),
		.line_dat_o (line_dat_o)
	);

endmodule

/* logic/line_merger.sv */
// Line merger: byte merge of CPU, cache and lane data, cache write and CPU ack
module line_merger
	import line_pkg::*;
(
	input  logic                 clk_i,
	input  logic                 rst_i,
	input  logic                 cpu_req_i,
	input  logic [BEATS-1:0]     lane_done_i,
	input  beat_t [BEATS-1:0]    lane_rdat_i,
	input  logic                 req_we_i,
	input  line_sel_t            req_sel_i,
	input  line_t                req_dat_i,
	input  logic                 use_cache_i,
	input  logic                 upd_line_i,
	input  line_t                cache_dat_i,
	output logic                 line_clr_o,
	output logic                 cpu_ack_o,
	output logic                 line_wr_o,
	output line_t                line_dat_o
);

	localparam int LINE_BYTES = $bits(line_sel_t);

	typedef enum logic [1:0] {
		M_COLLECT,
		M_ACK,
		M_RELEASE
	} merge_state_e;

	merge_state_e state;
	line_t lane_line;
	line_t merged;
	line_t line_q;

	// Beat 0 lands in the low bits of the line
	assign lane_line = lane_rdat_i;

	// ==================================================
	// Byte merge
	// ==================================================

	always_comb begin
		for (int i = 0; i < LINE_BYTES; i++) begin
			if (req_we_i && req_sel_i[i])
				merged[i*8 +: 8] = req_dat_i[i*8 +: 8];
			else if (use_cache_i)
				merged[i*8 +: 8] = cache_dat_i[i*8 +: 8];
			else
				merged[i*8 +: 8] = lane_line[i*8 +: 8];
		end
	end

	// ==================================================
	// CPU side FSM
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state     <= M_COLLECT;
			cpu_ack_o <= 1'b0;
			line_wr_o <= 1'b0;
		end else begin
			line_wr_o <= 1'b0;
			case (state)
			M_COLLECT:
				if (&lane_done_i) begin
					cpu_ack_o <= 1'b1;
					line_wr_o <= upd_line_i;
					state     <= M_ACK;
				end
			M_ACK:
				// Ack held until the CPU lets go
				if (!cpu_req_i)
					state <= M_RELEASE;
			M_RELEASE: begin
				cpu_ack_o <= 1'b0;
				state     <= M_COLLECT;
			end
			default:
				state <= M_COLLECT;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == M_COLLECT && &lane_done_i)
			line_q <= merged;
	end

	// Lanes and splitter return to idle together with ack
	assign line_clr_o = (state == M_RELEASE);
	assign line_dat_o = line_q;

endmodule

/* logic/beat_lane.sv */
// Beat lane: one four-phase transfer between a beat and its memory bank
module beat_lane
	import line_pkg::*, ctrl_pkg::*;
#(
	parameter int ADR_W = 26
) (
	input  logic             clk_i,
	input  logic             rst_i,
	input  logic             go_i,
	input  beat_op_e         op_i,
	input  logic [ADR_W-1:0] adr_i,
	input  beat_idx_t        beat_i,
	input  beat_t            wdat_i,
	input  beat_be_t         be_i,
	input  logic             bank_ack_i,
	input  beat_t            bank_rdat_i,
	input  logic             clr_i,
	output logic             bank_req_o,
	output logic             bank_we_o,
	output logic [ADR_W+1:0] bank_adr_o,
	output beat_be_t         bank_be_o,
	output beat_t            bank_wdat_o,
	output logic             done_o,
	output beat_t            rdat_o
);

	typedef enum logic [1:0] {
		L_IDLE,
		L_REQ,
		L_REL,
		L_DONE
	} lane_state_e;

	lane_state_e state;
	beat_t rdat_q;

	// ==================================================
	// Bank handshake FSM
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= L_IDLE;
		end else begin
			case (state)
			L_IDLE:
				if (go_i)
					state <= (op_i == SKIP) ? L_DONE : L_REQ;
			L_REQ:
				if (bank_ack_i)
					state <= L_REL;
			L_REL:
				// Wait for the bank to drop ack
				if (!bank_ack_i)
					state <= L_DONE;
			L_DONE:
				if (clr_i)
					state <= L_IDLE;
			default:
				state <= L_IDLE;
			endcase
		end
	end

	// Only a read leaves data behind
	always_ff @(posedge clk_i) begin
		if (state == L_IDLE && go_i)
			rdat_q <= '0;
		else if (state == L_REQ && bank_ack_i && op_i == READ)
			rdat_q <= bank_rdat_i;
	end

	// Request fields come straight from the latched request
	assign bank_req_o  = (state == L_REQ);
	assign bank_we_o   = (op_i == WRITE);
	assign bank_adr_o  = {adr_i, beat_i};
	assign bank_be_o   = be_i;
	assign bank_wdat_o = wdat_i;

	assign done_o = (state == L_DONE);
	assign rdat_o = rdat_q;

endmodule

/* logic/request_splitter.sv */
// Request splitter: CPU request latch, per-beat operation decode and cache update flags
module request_splitter
	import line_pkg::*, ctrl_pkg::*;
#(
	parameter int ADR_W = 26
) (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    cpu_req_i,
	input  logic                    cpu_we_i,
	input  logic                    cpu_nc_i,
	input  logic                    hit_i,
	input  logic [ADR_W-1:0]        cpu_adr_i,
	input  line_sel_t               cpu_sel_i,
	input  line_t                   cpu_dat_i,
	input  logic                    line_clr_i,
	output logic                    lane_go_o,
	output beat_op_e [BEATS-1:0]    lane_op_o,
	output logic [ADR_W-1:0]        req_adr_o,
	output logic                    req_we_o,
	output line_sel_t               req_sel_o,
	output line_t                   req_dat_o,
	output logic                    use_cache_o,
	output logic                    upd_line_o
);

	localparam int BEAT_BYTES = $bits(beat_be_t);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT
	} split_state_e;

	split_state_e state;
	logic req_nc;
	logic req_hit;
	logic [BEATS-1:0] beat_sel;

	// ==================================================
	// Request FSM
	// ==================================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= S_IDLE;
		end else begin
			case (state)
			S_IDLE:
				if (cpu_req_i)
					state <= S_ISSUE;
			S_ISSUE:
				state <= S_WAIT;
			S_WAIT:
				// Merger has drained the lanes
				if (line_clr_i)
					state <= S_IDLE;
			default:
				state <= S_IDLE;
			endcase
		end
	end

	// Request is held here until the line completes
	always_ff @(posedge clk_i) begin
		if (state == S_IDLE && cpu_req_i) begin
			req_adr_o <= cpu_adr_i;
			req_we_o  <= cpu_we_i;
			req_sel_o <= cpu_sel_i;
			req_dat_o <= cpu_dat_i;
			req_nc    <= cpu_nc_i;
			req_hit   <= hit_i;
		end
	end

	// All lanes start together
	assign lane_go_o = (state == S_ISSUE);

	// ==================================================
	// Beat decode
	// ==================================================

	always_comb begin
		for (int b = 0; b < BEATS; b++) begin
			beat_sel[b] = |req_sel_o[b*BEAT_BYTES +: BEAT_BYTES];
			if (req_we_o)
				lane_op_o[b] = beat_sel[b] ? WRITE : SKIP;
			else if (req_hit)
				lane_op_o[b] = SKIP;
			else if (!req_nc)
				lane_op_o[b] = READ;  // full line load on a miss
			else
				lane_op_o[b] = beat_sel[b] ? READ : SKIP;
		end
	end

	// Read miss loads the line, write hit updates it
	assign upd_line_o  = !req_nc && (req_we_o ? req_hit : !req_hit);
	assign use_cache_o = req_hit;

endmodule

/* logic/ctrl_pkg.sv */
// Beat operation encoding shared by the request splitter and the beat lanes
package ctrl_pkg;

	// What a lane does with its beat
	typedef enum logic [1:0] {
		SKIP,
		READ,
		WRITE
	} beat_op_e;

endpackage

/* logic/line_pkg.sv */
// Line, beat, byte select and beat index types for the line controller
package line_pkg;

	// ==================================================
	// Line layout
	// ==================================================

	// A line is carried to memory as four beats
	localparam int BEATS = 4;

	// One memory beat of 128 bits
	typedef logic [127:0] beat_t;

	// Byte enables of one beat
	typedef logic [15:0] beat_be_t;

	// A full cache line, beat 0 in the low bits
	typedef logic [511:0] line_t;

	// Byte selects of a full line, one per byte
	typedef logic [63:0] line_sel_t;

	// Beat number within a line, also the bank number
	typedef logic [1:0] beat_idx_t;

endpackage
